// File: Makefile
# Verilator build and run of the memory controller testbench

VERILATOR ?= verilator
TOP       ?= memCtrlTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/memAccessIf.sv
`default_nettype none

interface memReqIf #(
    parameter int AddrWidth = 32
);
    logic                              start;
    memCtrlPkg::accessOp_t             op;
    logic [AddrWidth-1:0]              addr;
    memCtrlPkg::accessLen_t            len;
    logic [memCtrlPkg::WordWidth-1:0]  wdata;
    logic                              finished;

    modport arbiter (output start, op, addr, len, wdata, input finished);
    modport sequencer (input start, op, addr, len, wdata, output finished);
endinterface

interface memBeatIf;
    logic                   readIssued;
    memCtrlPkg::byteIdx_t   byteIdx;
    logic                   lastByte;
    memCtrlPkg::accessOp_t  op;
    logic                   writeLast;
    logic                   done;

    modport sequencer (
        output readIssued, byteIdx, lastByte, op, writeLast,
        input  done
    );
    modport assembler (
        input  readIssued, byteIdx, lastByte, op, writeLast,
        output done
    );
endinterface

`default_nettype wire

// File: hdl/memByteSequencer.sv
`default_nettype none

module memByteSequencer #(
    parameter int AddrWidth = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_stall,

    output logic [AddrWidth-1:0]              o_memAddr,
    output logic                              o_memWr,
    output logic [memCtrlPkg::ByteWidth-1:0]  o_memData,

    memReqIf.sequencer                        reqIf,
    memBeatIf.sequencer                       beatIf
);
    typedef enum logic [1:0] {
        seqIdle,
        seqRun,
        seqWait
    } seqState_t;

    seqState_t            state;
    memCtrlPkg::byteIdx_t cnt;
    logic                 running;
    logic                 isStore;
    logic                 isLast;
    logic                 step;

    always_comb begin
        running = state == seqRun;
        isStore = reqIf.op == memCtrlPkg::opStore;
        isLast  = cnt == memCtrlPkg::lastIdx(reqIf.len);
        // a byte only counts in a non-stalled cycle
        step    = running && !i_stall;
    end

    // start is a single pulse, so it is taken even when stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            cnt   <= '0;
        end else begin
            case (state)
                seqIdle: begin
                    if (reqIf.start) begin
                        state <= seqRun;
                        cnt   <= '0;
                    end
                end
                seqRun: begin
                    if (step) begin
                        if (isLast) begin
                            state <= seqWait;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                seqWait: begin
                    if (beatIf.done) begin
                        state <= seqIdle;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // RAM side
    always_comb begin
        o_memAddr = running ? reqIf.addr + AddrWidth'(cnt) : '0;
        o_memWr   = step && isStore;
        o_memData = (running && isStore) ?
            reqIf.wdata[cnt*memCtrlPkg::ByteWidth +: memCtrlPkg::ByteWidth] : '0;
    end

    // beats towards the assembler
    always_comb begin
        beatIf.readIssued = step && !isStore;
        beatIf.byteIdx    = cnt;
        beatIf.lastByte   = isLast;
        beatIf.op         = reqIf.op;
        beatIf.writeLast  = step && isStore && isLast;
        reqIf.finished    = (state == seqWait) && beatIf.done;
    end

endmodule

`default_nettype wire

// File: hdl/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    // RAM is byte wide, words are little-endian
    parameter int ByteWidth = 8;
    parameter int WordBytes = 4;
    parameter int WordWidth = ByteWidth * WordBytes;

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore
    } accessOp_t;

    // encoded as the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_t;

    typedef logic [$clog2(WordBytes)-1:0] byteIdx_t;

    // index of the final byte of an access
    function automatic byteIdx_t lastIdx(accessLen_t len);
        logic [2:0] count;
        count = len;
        return byteIdx_t'(count - 3'd1);
    endfunction

endpackage

`default_nettype wire

// File: hdl/memCtrlTop.sv
`default_nettype none

module memCtrlTop #(
    parameter int AddrWidth = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_rdy,
    input  logic                              i_ioBufferFull,
    input  logic [memCtrlPkg::ByteWidth-1:0]  i_memRdata,

    // byte RAM
    output logic [AddrWidth-1:0]              o_memAddr,
    output logic                              o_memWr,
    output logic [memCtrlPkg::ByteWidth-1:0]  o_memData,

    // instruction fetch
    input  logic                              i_fetchEn,
    input  logic [AddrWidth-1:0]              i_fetchAddr,
    output logic                              o_fetchDone,
    output logic [memCtrlPkg::WordWidth-1:0]  o_fetchInst,

    // data cache
    input  logic                              i_dataEn,
    input  logic                              i_dataStore,
    input  memCtrlPkg::accessLen_t            i_dataLen,
    input  logic [AddrWidth-1:0]              i_dataAddr,
    input  logic [memCtrlPkg::WordWidth-1:0]  i_dataWdata,
    output logic                              o_dataDone,
    output logic [memCtrlPkg::WordWidth-1:0]  o_dataRdata
);
    logic stall;

    // the only source of back-pressure
    assign stall = i_ioBufferFull || !i_rdy;

    memReqIf #(.AddrWidth(AddrWidth)) reqIf ();
    memBeatIf beatIf ();

    memReqArbiter #(.AddrWidth(AddrWidth)) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_stall     (stall),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .reqIf       (reqIf.arbiter)
    );

    memByteSequencer #(.AddrWidth(AddrWidth)) u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .i_stall   (stall),
        .o_memAddr (o_memAddr),
        .o_memWr   (o_memWr),
        .o_memData (o_memData),
        .reqIf     (reqIf.sequencer),
        .beatIf    (beatIf.sequencer)
    );

    memWordAssembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .i_memRdata  (i_memRdata),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .beatIf      (beatIf.assembler)
    );

endmodule

`default_nettype wire

// File: hdl/memReqArbiter.sv
`default_nettype none

module memReqArbiter #(
    parameter int AddrWidth = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_stall,

    input  logic                              i_fetchEn,
    input  logic [AddrWidth-1:0]              i_fetchAddr,

    input  logic                              i_dataEn,
    input  logic                              i_dataStore,
    input  memCtrlPkg::accessLen_t            i_dataLen,
    input  logic [AddrWidth-1:0]              i_dataAddr,
    input  logic [memCtrlPkg::WordWidth-1:0]  i_dataWdata,

    memReqIf.arbiter                          reqIf
);
    logic busy;
    logic servedFetch;
    logic canAccept;
    logic takeData;
    logic takeFetch;

    // a new access may start in the same edge as finished
    always_comb begin
        canAccept = !i_stall && (!busy || reqIf.finished);
        // the served requester's enable is still up at that edge
        takeData  = canAccept && i_dataEn && !(busy && !servedFetch);
        takeFetch = canAccept && !takeData && i_fetchEn && !(busy && servedFetch);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            servedFetch <= 1'b0;
            reqIf.start <= 1'b0;
        end else begin
            reqIf.start <= takeData || takeFetch;
            if (takeData || takeFetch) begin
                busy        <= 1'b1;
                servedFetch <= takeFetch;
            end else if (reqIf.finished) begin
                busy <= 1'b0;
            end
        end
    end

    // request fields, held until the access ends
    always_ff @(posedge clk) begin
        if (takeData) begin
            reqIf.op    <= i_dataStore ? memCtrlPkg::opStore : memCtrlPkg::opLoad;
            reqIf.addr  <= i_dataAddr;
            reqIf.len   <= i_dataLen;
            reqIf.wdata <= i_dataWdata;
        end else if (takeFetch) begin
            // instructions are always a full word
            reqIf.op    <= memCtrlPkg::opFetch;
            reqIf.addr  <= i_fetchAddr;
            reqIf.len   <= memCtrlPkg::lenWord;
        end
    end

endmodule

`default_nettype wire

// File: hdl/memWordAssembler.sv
`default_nettype none

module memWordAssembler (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [memCtrlPkg::ByteWidth-1:0]  i_memRdata,

    output logic                              o_fetchDone,
    output logic [memCtrlPkg::WordWidth-1:0]  o_fetchInst,
    output logic                              o_dataDone,
    output logic [memCtrlPkg::WordWidth-1:0]  o_dataRdata,

    memBeatIf.assembler                       beatIf
);
    logic                             issuedQ;
    memCtrlPkg::byteIdx_t             idxQ;
    logic                             lastQ;
    logic                             fetchQ;
    logic [memCtrlPkg::WordWidth-1:0] wordQ;
    logic [memCtrlPkg::WordWidth-1:0] nextWord;
    logic                             fetchDoneQ;
    logic                             dataDoneQ;

    // RAM data arrives one cycle after the issue
    always_ff @(posedge clk) begin
        idxQ   <= beatIf.byteIdx;
        lastQ  <= beatIf.lastByte;
        fetchQ <= beatIf.op == memCtrlPkg::opFetch;
    end

    // byte 0 clears the word, which zero-extends short loads
    always_comb begin
        nextWord = (idxQ == '0) ? '0 : wordQ;
        nextWord[idxQ*memCtrlPkg::ByteWidth +: memCtrlPkg::ByteWidth] = i_memRdata;
    end

    always_ff @(posedge clk) begin
        if (issuedQ) begin
            wordQ <= nextWord;
            if (lastQ && fetchQ) begin
                o_fetchInst <= nextWord;
            end
            if (lastQ && !fetchQ) begin
                o_dataRdata <= nextWord;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issuedQ    <= 1'b0;
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
        end else begin
            issuedQ    <= beatIf.readIssued;
            fetchDoneQ <= issuedQ && lastQ && fetchQ;
            // stores finish one cycle after the final write
            dataDoneQ  <= (issuedQ && lastQ && !fetchQ) || beatIf.writeLast;
        end
    end

    assign o_fetchDone = fetchDoneQ;
    assign o_dataDone  = dataDoneQ;
    assign beatIf.done = fetchDoneQ || dataDoneQ;

endmodule

`default_nettype wire

// File: verif/memCtrlChecker.sv
`default_nettype none

module memCtrlChecker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_rdy,
    input  logic                              i_ioBufferFull,
    input  logic                              i_memWr,
    input  logic                              i_fetchDone,
    input  logic [memCtrlPkg::WordWidth-1:0]  i_fetchInst,
    input  logic                              i_dataDone,
    input  logic [memCtrlPkg::WordWidth-1:0]  i_dataRdata,
    // what the bench currently expects
    input  logic                              i_fetchArmed,
    input  logic [memCtrlPkg::WordWidth-1:0]  i_fetchExp,
    input  logic                              i_dataArmed,
    input  logic                              i_dataIsStore,
    input  logic [memCtrlPkg::WordWidth-1:0]  i_dataExp,
    output int                                o_errors,
    output int                                o_checks
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int checks = 0;

    always @(posedge clk) begin
        if (!rst) begin
            if (i_memWr && (i_ioBufferFull || !i_rdy)) begin
                $display("RAM write enable was high in a stalled cycle at %0t", $time);
                errors++;
            end
            if (i_memWr && !(i_dataArmed && i_dataIsStore)) begin
                $display("RAM write at %0t while no store was pending", $time);
                errors++;
            end
            if (i_fetchDone) begin
                if (!i_fetchArmed) begin
                    $display("fetch done pulse at %0t with no fetch pending", $time);
                    errors++;
                end else begin
                    checks++;
                    if (i_fetchInst !== i_fetchExp) begin
                        $display("[FAIL] t=%0t fetch returned %h, expected %h",
                            $time, i_fetchInst, i_fetchExp);
                        errors++;
                    end
                    // fetches are never raised ahead of a data access here
                    if (i_dataArmed) begin
                        $display("fetch finished before the pending data access at %0t", $time);
                        errors++;
                    end
                end
            end
            if (i_dataDone) begin
                if (!i_dataArmed) begin
                    $display("data done pulse at %0t with no data access pending", $time);
                    errors++;
                end else begin
                    checks++;
                    if (!i_dataIsStore && i_dataRdata !== i_dataExp) begin
                        $display("[FAIL] t=%0t load returned %h, expected %h",
                            $time, i_dataRdata, i_dataExp);
                        errors++;
                    end
                end
            end
        end
    end

    assign o_errors = errors;
    assign o_checks = checks;

endmodule

`default_nettype wire

// File: verif/memCtrlTb.sv
`default_nettype none

module memCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AddrWidth     = 32;
    localparam int Cols          = 5;
    localparam int MaxLines      = 64;
    localparam int StallFrom     = 15;
    localparam int TimeoutCycles = 100;

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             rdy = 1'b1;
    logic                             ioBufferFull = 1'b0;
    logic [memCtrlPkg::ByteWidth-1:0] memRdata = '0;
    logic [AddrWidth-1:0]             memAddr;
    logic                             memWr;
    logic [memCtrlPkg::ByteWidth-1:0] memData;
    logic                             fetchEn;
    logic [AddrWidth-1:0]             fetchAddr;
    logic                             fetchDone;
    logic [memCtrlPkg::WordWidth-1:0] fetchInst;
    logic                             dataEn;
    logic                             dataStore;
    memCtrlPkg::accessLen_t           dataLen;
    logic [AddrWidth-1:0]             dataAddr;
    logic [memCtrlPkg::WordWidth-1:0] dataWdata;
    logic                             dataDone;
    logic [memCtrlPkg::WordWidth-1:0] dataRdata;

    logic                             fetchArmed;
    logic                             dataArmed;
    logic                             dataIsStore;
    logic [memCtrlPkg::WordWidth-1:0] fetchExp;
    logic [memCtrlPkg::WordWidth-1:0] dataExp;
    logic                             stallOn;
    logic [31:0]                      lfsr = 32'h84a0;
    logic [31:0]                      vec [0:MaxLines*Cols-1];
    logic [memCtrlPkg::ByteWidth-1:0] ram [0:255];
    int                               errors;
    int                               checks;
    int                               timeouts = 0;
    logic                             aborted = 1'b0;

    always #20 clk = ~clk;

    memCtrlTop #(.AddrWidth(AddrWidth)) u_dut (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioBufferFull),
        .i_memRdata(memRdata), .o_memAddr(memAddr), .o_memWr(memWr), .o_memData(memData),
        .i_fetchEn(fetchEn), .i_fetchAddr(fetchAddr), .o_fetchDone(fetchDone),
        .o_fetchInst(fetchInst), .i_dataEn(dataEn), .i_dataStore(dataStore),
        .i_dataLen(dataLen), .i_dataAddr(dataAddr), .i_dataWdata(dataWdata),
        .o_dataDone(dataDone), .o_dataRdata(dataRdata)
    );

    memCtrlChecker u_checker (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioBufferFull), .i_memWr(memWr),
        .i_fetchDone(fetchDone), .i_fetchInst(fetchInst), .i_dataDone(dataDone),
        .i_dataRdata(dataRdata), .i_fetchArmed(fetchArmed), .i_fetchExp(fetchExp),
        .i_dataArmed(dataArmed), .i_dataIsStore(dataIsStore), .i_dataExp(dataExp),
        .o_errors(errors), .o_checks(checks)
    );

    // byte RAM, one cycle read latency, pattern a*7+3
    initial begin
        for (int a = 0; a < 256; a++) begin
            ram[a] <= 8'(a * 7 + 3);
        end
    end

    always @(posedge clk) begin
        memRdata <= ram[memAddr[7:0]];
        if (memWr) begin
            ram[memAddr[7:0]] <= memData;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // three zero bits give a stall on about one cycle in eight
    always @(posedge clk) begin : stallGen
        logic [3:0] bits;
        for (int i = 0; i < 4; i++) begin
            lfsr = lfsrNext(lfsr);
            bits[i] = lfsr[0];
        end
        if (stallOn && bits[2:0] == 3'b000) begin
            rdy          <= bits[3];
            ioBufferFull <= !bits[3];
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    end

    task automatic raiseFetch(input int row);
        fetchEn    <= 1'b1;
        fetchAddr  <= vec[row*Cols+1];
        fetchExp   <= vec[row*Cols+4];
        fetchArmed <= 1'b1;
    endtask

    task automatic raiseData(input int row);
        dataEn      <= 1'b1;
        dataStore   <= vec[row*Cols] == 32'd2;
        dataLen     <= memCtrlPkg::accessLen_t'(vec[row*Cols+2][2:0]);
        dataAddr    <= vec[row*Cols+1];
        dataWdata   <= vec[row*Cols+3];
        dataExp     <= vec[row*Cols+4];
        dataIsStore <= vec[row*Cols] == 32'd2;
        dataArmed   <= 1'b1;
    endtask

    // requester drops its enable right after its done pulse
    task automatic waitDone(input logic wantFetch, input logic wantData, input int row);
        int   cycles;
        logic fetchLeft;
        logic dataLeft;
        cycles    = 0;
        fetchLeft = wantFetch;
        dataLeft  = wantData;
        while ((fetchLeft || dataLeft) && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
            if (fetchLeft && fetchDone) begin
                fetchLeft = 1'b0;
                fetchEn    <= 1'b0;
                fetchArmed <= 1'b0;
            end
            if (dataLeft && dataDone) begin
                dataLeft  = 1'b0;
                dataEn    <= 1'b0;
                dataArmed <= 1'b0;
            end
        end
        if (fetchLeft || dataLeft) begin
            $display("timeout: access on data line %0d got no done pulse in %0d cycles",
                row + 1, TimeoutCycles);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int row;
        int accesses;
        rst <= 1'b1;
        fetchEn <= 1'b0;
        fetchAddr <= '0;
        dataEn <= 1'b0;
        dataStore <= 1'b0;
        dataLen <= memCtrlPkg::lenByte;
        dataAddr <= '0;
        dataWdata <= '0;
        fetchArmed <= 1'b0;
        dataArmed <= 1'b0;
        dataIsStore <= 1'b0;
        fetchExp <= '0;
        dataExp <= '0;
        stallOn <= 1'b0;
        for (int i = 0; i < MaxLines * Cols; i++) begin
            vec[i] = '1;
        end
        $readmemh("verif/testdata.txt", vec);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // idle, nothing may pulse or write
        repeat (8) @(posedge clk);
        row = 0;
        accesses = 0;
        while (row < MaxLines && vec[row*Cols] != 32'hff && !aborted) begin
            @(posedge clk);
            if (row >= StallFrom) begin
                stallOn <= 1'b1;
            end
            if (vec[row*Cols] == 32'd3) begin
                raiseFetch(row);
                raiseData(row + 1);
                accesses += 2;
                waitDone(1'b1, 1'b1, row);
                row += 2;
            end else if (vec[row*Cols] == 32'd0) begin
                raiseFetch(row);
                accesses++;
                waitDone(1'b1, 1'b0, row);
                row++;
            end else begin
                raiseData(row);
                accesses++;
                waitDone(1'b0, 1'b1, row);
                row++;
            end
        end
        repeat (4) @(posedge clk);
        if (accesses == 0) begin
            $display("no accesses were read from verif/testdata.txt");
        end else if (checks != accesses) begin
            $display("%0d accesses were run but %0d done pulses were checked", accesses, checks);
        end
        $display("accesses %0d, checks %0d, errors %0d, timeouts %0d",
            accesses, checks, errors, timeouts);
        if (accesses > 0 && checks == accesses && errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/testdata.txt
// columns: op addr len wdata expected, all hex
// op 0 fetch, 1 load, 2 store, 3 fetch raised together with next line, ff end
0 00000000 4 00000000 18110a03
0 00000005 4 00000000 3b342d26
1 00000007 1 00000000 00000034
1 00000009 2 00000000 00004942
1 00000020 4 00000000 f8f1eae3
2 00000040 1 000000a5 00000000
1 00000040 4 00000000 d8d1caa5
2 00000050 2 deadbeef 00000000
1 00000050 4 00000000 4841beef
2 00000060 4 12345678 00000000
1 00000060 4 00000000 12345678
1 00000062 2 00000000 00001234
0 00000060 4 00000000 12345678
3 00000010 4 00000000 88817a73
1 00000014 4 00000000 a49d968f
0 00000030 4 00000000 68615a53
2 00000070 4 cafef00d 00000000
1 00000072 1 00000000 000000fe
2 00000091 1 00000077 00000000
1 00000090 4 00000000 080177f3
3 00000080 4 00000000 98918a83
2 000000a0 2 0000beef 00000000
1 000000a0 4 00000000 7871beef
1 000000fe 2 00000000 0000fcf5
1 00000043 1 00000000 000000d8
0 00000040 4 00000000 d8d1caa5
ff 00000000 0 00000000 00000000

// File: verilog.f
hdl/memCtrlPkg.sv
hdl/memAccessIf.sv
hdl/memReqArbiter.sv
hdl/memByteSequencer.sv
hdl/memWordAssembler.sv
hdl/memCtrlTop.sv
verif/memCtrlChecker.sv
verif/memCtrlTb.sv
